//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = mem_arbiter_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- src/mem_arb_pkg.sv
package mem_arb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus field types
    ////////////////////////////////////////////////////////////////////////////

    // byte address on the memory bus
    typedef logic [31:0] addr_t;
    // one bus data word
    typedef logic [63:0] mem_data_t;
    // transaction tag, 0 means none or refused
    typedef logic [3:0]  mem_tag_t;
    // bus command code
    typedef logic [1:0]  bus_cmd_t;
    // which requester issued a transaction
    typedef logic [1:0]  owner_t;

    // command codes, same as the memory model
    localparam bus_cmd_t BUS_NONE  = 2'b00;
    localparam bus_cmd_t BUS_LOAD  = 2'b01;
    localparam bus_cmd_t BUS_STORE = 2'b10;

    // owner codes, 2'b11 never used
    localparam owner_t OWN_NONE = 2'b00;
    localparam owner_t OWN_D    = 2'b01;
    localparam owner_t OWN_I    = 2'b10;

    // one slot per tag value, slot 0 stays empty
    localparam int TAG_COUNT = 16;
    // outstanding data counter, holds up to 15
    localparam int PEND_W    = 5;

    ////////////////////////////////////////////////////////////////////////////
    // request and reply bundles
    ////////////////////////////////////////////////////////////////////////////

    // request from a requester toward memory, 98 bits
    typedef struct packed {
        bus_cmd_t  command;
        addr_t     addr;
        mem_data_t data;
    } mem_req_t;

    // reply from memory, present when tag is nonzero, 68 bits
    typedef struct packed {
        mem_tag_t  tag;
        mem_data_t data;
    } mem_reply_t;

endpackage

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                    clock,
    input  logic                    reset,
    // requesters
    input  mem_arb_pkg::mem_req_t   icache_req,
    input  mem_arb_pkg::mem_req_t   dcache_req,
    // memory side
    input  mem_arb_pkg::mem_tag_t   mem_response,
    input  mem_arb_pkg::mem_reply_t mem_reply,
    output mem_arb_pkg::mem_req_t   mem_req,
    // acceptance tags back to the requesters
    output mem_arb_pkg::mem_tag_t   icache_response,
    output mem_arb_pkg::mem_tag_t   dcache_response,
    // replies one cycle after memory
    output mem_arb_pkg::mem_reply_t icache_reply,
    output mem_arb_pkg::mem_reply_t dcache_reply,
    output logic                    dcache_stall
);

    import mem_arb_pkg::*;

    // winner of the bus this cycle
    owner_t issue_owner;
    // owner of the reply arriving now
    owner_t reply_owner;
    logic   data_pending;

    ////////////////////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////////////////////

    mem_request_select req_select0 (
        .icache_req      (icache_req),
        .dcache_req      (dcache_req),
        .mem_response    (mem_response),
        .mem_req         (mem_req),
        .icache_response (icache_response),
        .dcache_response (dcache_response),
        .issue_owner     (issue_owner)
    );

    ////////////////////////////////////////////////////////////////////////////
    // tag bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    // acceptance tag and reply tag straight from memory
    tag_owner_table owner_table0 (
        .clock        (clock),
        .reset        (reset),
        .accept_tag   (mem_response),
        .issue_owner  (issue_owner),
        .reply_tag    (mem_reply.tag),
        .reply_owner  (reply_owner),
        .data_pending (data_pending)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reply side
    ////////////////////////////////////////////////////////////////////////////

    reply_router router0 (
        .clock        (clock),
        .reset        (reset),
        .mem_reply    (mem_reply),
        .reply_owner  (reply_owner),
        .dcache_cmd   (dcache_req.command),
        .data_pending (data_pending),
        .icache_reply (icache_reply),
        .dcache_reply (dcache_reply),
        .dcache_stall (dcache_stall)
    );

endmodule

//--- src/mem_request_select.sv
`timescale 1ns/1ps

module mem_request_select (
    // instruction fetch request, loads only
    input  mem_arb_pkg::mem_req_t icache_req,
    // data cache request, loads and stores
    input  mem_arb_pkg::mem_req_t dcache_req,
    // same-cycle acceptance tag from memory
    input  mem_arb_pkg::mem_tag_t mem_response,
    // request driven onto the shared bus
    output mem_arb_pkg::mem_req_t mem_req,
    output mem_arb_pkg::mem_tag_t icache_response,
    output mem_arb_pkg::mem_tag_t dcache_response,
    // winner of this cycle, to the owner table
    output mem_arb_pkg::owner_t   issue_owner
);

    import mem_arb_pkg::*;

    logic icache_present;
    logic dcache_present;

    assign icache_present = icache_req.command != BUS_NONE;
    assign dcache_present = dcache_req.command != BUS_NONE;

    ////////////////////////////////////////////////////////////////////////////
    // priority choice
    ////////////////////////////////////////////////////////////////////////////

    // data side first, fetch only on an idle data side
    always_comb begin
        if (dcache_present) begin
            mem_req     = dcache_req;
            issue_owner = OWN_D;
        end else if (icache_present) begin
            mem_req     = icache_req;
            issue_owner = OWN_I;
        end else begin
            // idle bus, nothing to record
            mem_req     = '0;
            issue_owner = OWN_NONE;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response steering
    ////////////////////////////////////////////////////////////////////////////

    // loser sees 0 and retries like a refusal
    always_comb begin
        icache_response = '0;
        dcache_response = '0;
        case (issue_owner)
            OWN_D: begin
                dcache_response = mem_response;
            end
            OWN_I: begin
                icache_response = mem_response;
            end
            default: begin
                // no request, no response
            end
        endcase
    end

    // fetch side never writes memory
    always_comb begin
        assert (icache_req.command != BUS_STORE)
            else $error("icache request carries a store command");
    end

endmodule

//--- src/reply_router.sv
`timescale 1ns/1ps

module reply_router (
    input  logic                    clock,
    input  logic                    reset,
    // reply straight from memory
    input  mem_arb_pkg::mem_reply_t mem_reply,
    // owner looked up for mem_reply.tag
    input  mem_arb_pkg::owner_t     reply_owner,
    // data side command on its request port
    input  mem_arb_pkg::bus_cmd_t   dcache_cmd,
    input  logic                    data_pending,
    output mem_arb_pkg::mem_reply_t icache_reply,
    output mem_arb_pkg::mem_reply_t dcache_reply,
    output logic                    dcache_stall
);

    import mem_arb_pkg::*;

    // reply tag registers
    mem_tag_t  icache_tag_q;
    mem_tag_t  dcache_tag_q;
    // reply payload
    mem_data_t icache_data_q;
    mem_data_t dcache_data_q;

    ////////////////////////////////////////////////////////////////////////////
    // one-cycle reply registers
    ////////////////////////////////////////////////////////////////////////////

    // owner port loads the reply, the other goes to 0
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            icache_tag_q <= '0;
            dcache_tag_q <= '0;
        end else begin
            icache_tag_q <= (reply_owner == OWN_I) ? mem_reply.tag : '0;
            dcache_tag_q <= (reply_owner == OWN_D) ? mem_reply.tag : '0;
        end
    end

    // payload goes to the owner port only
    always_ff @(posedge clock) begin
        icache_data_q <= (reply_owner == OWN_I) ? mem_reply.data : '0;
        dcache_data_q <= (reply_owner == OWN_D) ? mem_reply.data : '0;
    end

    assign icache_reply = '{tag: icache_tag_q, data: icache_data_q};
    assign dcache_reply = '{tag: dcache_tag_q, data: dcache_data_q};

    ////////////////////////////////////////////////////////////////////////////
    // data stall
    ////////////////////////////////////////////////////////////////////////////

    // request on the bus or anything still in flight
    assign dcache_stall = (dcache_cmd != BUS_NONE) || data_pending;

    // every reply from memory must land somewhere
    a_reply_has_owner: assert property (@(posedge clock) disable iff (reset)
        (mem_reply.tag != '0) |-> (reply_owner != OWN_NONE))
        else $error("reply tag %0d dropped, no owner", mem_reply.tag);

endmodule

//--- src/tag_owner_table.sv
`timescale 1ns/1ps

module tag_owner_table (
    input  logic                  clock,
    input  logic                  reset,
    // tag memory returned for the request on the bus
    input  mem_arb_pkg::mem_tag_t accept_tag,
    // requester that won the bus this cycle
    input  mem_arb_pkg::owner_t   issue_owner,
    // tag of the reply arriving from memory
    input  mem_arb_pkg::mem_tag_t reply_tag,
    // owner of the arriving reply, same cycle
    output mem_arb_pkg::owner_t   reply_owner,
    // any data transaction still outstanding
    output logic                  data_pending
);

    import mem_arb_pkg::*;

    // owner per live tag
    owner_t owner_mem [TAG_COUNT];

    // outstanding data transactions
    logic [PEND_W-1:0] pend_count;

    logic accept_hit;
    logic reply_hit;
    logic data_issue;
    logic data_retire;

    ////////////////////////////////////////////////////////////////////////////
    // accept and reply decode
    ////////////////////////////////////////////////////////////////////////////

    // accepted only with a real winner and a nonzero tag
    assign accept_hit = (accept_tag != '0) && (issue_owner != OWN_NONE);
    assign reply_hit  = reply_tag != '0;

    // combinational lookup for the router
    assign reply_owner = reply_hit ? owner_mem[reply_tag] : OWN_NONE;

    assign data_issue  = accept_hit && (issue_owner == OWN_D);
    assign data_retire = reply_hit && (reply_owner == OWN_D);

    ////////////////////////////////////////////////////////////////////////////
    // owner slots
    ////////////////////////////////////////////////////////////////////////////

    // entry visible one cycle after acceptance
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < TAG_COUNT; i++) begin
                owner_mem[i] <= OWN_NONE;
            end
        end else begin
            // reply frees its slot
            if (reply_hit) begin
                owner_mem[reply_tag] <= OWN_NONE;
            end
            // never the same slot as the reply, see below
            if (accept_hit) begin
                owner_mem[accept_tag] <= issue_owner;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data-side occupancy
    ////////////////////////////////////////////////////////////////////////////

    // issue and retire in one cycle cancel out
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pend_count <= '0;
        end else begin
            case ({data_issue, data_retire})
                2'b10:   pend_count <= pend_count + 1'b1;
                2'b01:   pend_count <= pend_count - 1'b1;
                default: pend_count <= pend_count;
            endcase
        end
    end

    assign data_pending = pend_count != '0;

    // memory must not hand out a live tag
    a_accept_slot_free: assert property (@(posedge clock) disable iff (reset)
        accept_hit |-> owner_mem[accept_tag] == OWN_NONE)
        else $error("tag %0d accepted while still live", accept_tag);

    // reply must match a tag accepted earlier
    a_reply_slot_live: assert property (@(posedge clock) disable iff (reset)
        reply_hit |-> owner_mem[reply_tag] != OWN_NONE)
        else $error("reply for tag %0d with no owner", reply_tag);

    // a tag cannot be answered in the cycle it is issued
    a_no_same_tag: assert property (@(posedge clock) disable iff (reset)
        !((accept_tag != '0) && (accept_tag == reply_tag)))
        else $error("tag %0d accepted and replied together", accept_tag);

endmodule

//--- tests/mem_arbiter_checks.svh
////////////////////////////////////////////////////////////////////////////
// reference model and random numbers
////////////////////////////////////////////////////////////////////////////

// load data, address over its inverse
function automatic mem_data_t mem_word(input addr_t addr);
    return {addr, ~addr};
endfunction

// LCG state, fixed seed
logic [31:0] lcg_state = 32'h61b7_4aa1;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// upper half only, low LCG bits repeat quickly
function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:16]) % n;
endfunction

function automatic addr_t random_addr();
    addr_t a;
    a = lcg_next();
    // word aligned
    a[2:0] = 3'b000;
    return a;
endfunction

// data side mixes loads and stores
function automatic mem_req_t random_data_req();
    mem_req_t r;
    r.addr = random_addr();
    if (rand_below(2) == 0) begin
        r.command = BUS_STORE;
        r.data    = {lcg_next(), lcg_next()};
    end else begin
        r.command = BUS_LOAD;
        r.data    = '0;
    end
    return r;
endfunction

// data side first, then fetch
function automatic owner_t winner_of(input mem_req_t i_req, input mem_req_t d_req);
    if (d_req.command != BUS_NONE) begin
        return OWN_D;
    end
    if (i_req.command != BUS_NONE) begin
        return OWN_I;
    end
    return OWN_NONE;
endfunction

////////////////////////////////////////////////////////////////////////////
// tag book
////////////////////////////////////////////////////////////////////////////

// per tag: issuer, expected reply data, reply due cycle
owner_t    book_owner [TAG_COUNT];
mem_data_t book_data  [TAG_COUNT];
int        book_due   [TAG_COUNT];

// reply shown on the bus one cycle back
mem_tag_t  exp_tag;
owner_t    exp_owner;
mem_data_t exp_data;

logic check_stall;
int   error_count;
int   stall_errors;
int   accepted_count;
int   delivered_count;

task automatic book_clear();
    for (int t = 0; t < TAG_COUNT; t++) begin
        book_owner[mem_tag_t'(t)] = OWN_NONE;
        book_data[mem_tag_t'(t)]  = '0;
        book_due[mem_tag_t'(t)]   = 0;
    end
    exp_tag   = '0;
    exp_owner = OWN_NONE;
    exp_data  = '0;
endtask

// tag 0 never given out
function automatic mem_tag_t lowest_free_tag();
    for (int t = 1; t < TAG_COUNT; t++) begin
        if (book_owner[mem_tag_t'(t)] == OWN_NONE) begin
            return mem_tag_t'(t);
        end
    end
    return '0;
endfunction

function automatic logic book_live();
    for (int t = 1; t < TAG_COUNT; t++) begin
        if (book_owner[mem_tag_t'(t)] != OWN_NONE) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic logic book_has_data();
    for (int t = 1; t < TAG_COUNT; t++) begin
        if (book_owner[mem_tag_t'(t)] == OWN_D) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

////////////////////////////////////////////////////////////////////////////
// compare
////////////////////////////////////////////////////////////////////////////

task automatic report_error(input string msg);
    $display("error %0t: %s", $time, msg);
    error_count++;
endtask

// owner port carries the booked reply, the other stays all zero
task automatic check_port(input string name, input mem_reply_t got, input logic mine);
    if (mine && exp_tag != '0) begin
        if (got.tag != exp_tag || got.data != exp_data) begin
            report_error($sformatf("%s tag %0d data %h, expected tag %0d data %h",
                name, got.tag, got.data, exp_tag, exp_data));
        end else begin
            delivered_count++;
        end
    end else if (got.tag != '0 || got.data != '0) begin
        report_error($sformatf("%s tag %0d data %h, expected tag 0 data 0",
            name, got.tag, got.data));
    end
endtask

// sampled on the rising edge, inputs settled since the falling one
task automatic compare_cycle();
    owner_t   win;
    mem_req_t bus_exp;
    mem_tag_t i_resp_exp;
    mem_tag_t d_resp_exp;
    logic     stall_exp;
    win        = winner_of(icache_req, dcache_req);
    bus_exp    = '0;
    i_resp_exp = '0;
    d_resp_exp = '0;
    if (win == OWN_D) begin
        bus_exp    = dcache_req;
        d_resp_exp = mem_response;
    end else if (win == OWN_I) begin
        bus_exp    = icache_req;
        i_resp_exp = mem_response;
    end
    if (mem_req != bus_exp) begin
        report_error($sformatf("mem_req %h, expected %h", mem_req, bus_exp));
    end
    if (icache_response != i_resp_exp) begin
        report_error($sformatf("icache_response %0d, expected %0d",
            icache_response, i_resp_exp));
    end
    if (dcache_response != d_resp_exp) begin
        report_error($sformatf("dcache_response %0d, expected %0d",
            dcache_response, d_resp_exp));
    end
    check_port("icache_reply", icache_reply, exp_owner == OWN_I);
    check_port("dcache_reply", dcache_reply, exp_owner == OWN_D);
    if (check_stall) begin
        // data command driven, or a data tag still booked
        stall_exp = (dcache_req.command != BUS_NONE) || book_has_data();
        if (dcache_stall != stall_exp) begin
            $display("error %0t: dcache_stall %0b, expected %0b",
                $time, dcache_stall, stall_exp);
            stall_errors++;
        end
    end
endtask

//--- tests/mem_arbiter_tb.sv
`timescale 1ns/1ps

module mem_arbiter_tb;

    import mem_arb_pkg::*;

    // about twice the summed test length
    localparam int WATCHDOG_CYCLES = 6000;

    logic       clock;
    logic       reset;
    mem_req_t   icache_req;
    mem_req_t   dcache_req;
    mem_tag_t   mem_response;
    mem_reply_t mem_reply;
    mem_req_t   mem_req;
    mem_tag_t   icache_response;
    mem_tag_t   dcache_response;
    mem_reply_t icache_reply;
    mem_reply_t dcache_reply;
    logic       dcache_stall;

    // requester accepted in the last memory cycle
    owner_t accept_owner;
    int     cycle_count;
    int     pass_count;
    int     fail_count;

    `include "mem_arbiter_checks.svh"

    mem_arbiter dut0 (
        .clock           (clock),
        .reset           (reset),
        .icache_req      (icache_req),
        .dcache_req      (dcache_req),
        .mem_response    (mem_response),
        .mem_reply       (mem_reply),
        .mem_req         (mem_req),
        .icache_response (icache_response),
        .dcache_response (dcache_response),
        .icache_reply    (icache_reply),
        .dcache_reply    (dcache_reply),
        .dcache_stall    (dcache_stall)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        compare_cycle();
    end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////////////////////

    // one bus cycle, run right after the requests are driven
    task automatic memory_cycle();
        owner_t   win;
        mem_req_t win_req;
        mem_tag_t tag;
        mem_tag_t rep;
        // last reply now delivered, its tag goes free
        exp_tag   = mem_reply.tag;
        exp_owner = book_owner[mem_reply.tag];
        exp_data  = book_data[mem_reply.tag];
        if (mem_reply.tag != '0) begin
            book_owner[mem_reply.tag] = OWN_NONE;
        end
        win          = winner_of(icache_req, dcache_req);
        win_req      = (win == OWN_D) ? dcache_req : icache_req;
        tag          = lowest_free_tag();
        accept_owner = OWN_NONE;
        mem_response = '0;
        // accept 3 times in 4
        if (win != OWN_NONE && tag != '0 && rand_below(4) != 0) begin
            mem_response    = tag;
            accept_owner    = win;
            book_owner[tag] = win;
            book_data[tag]  = (win_req.command == BUS_LOAD) ? mem_word(win_req.addr) : '0;
            book_due[tag]   = cycle_count + 2 + rand_below(8);
            accepted_count++;
        end
        // oldest due reply, one per cycle
        rep = '0;
        for (int t = 1; t < TAG_COUNT; t++) begin
            if (book_owner[mem_tag_t'(t)] != OWN_NONE &&
                book_due[mem_tag_t'(t)] <= cycle_count) begin
                if (rep == '0 || book_due[mem_tag_t'(t)] < book_due[rep]) begin
                    rep = mem_tag_t'(t);
                end
            end
        end
        mem_reply = '{tag: rep, data: (rep != '0) ? book_data[rep] : '0};
        cycle_count++;
    endtask

    task automatic bus_cycle(input mem_req_t i_req, input mem_req_t d_req);
        @(negedge clock);
        icache_req = i_req;
        dcache_req = d_req;
        memory_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // requesters
    ////////////////////////////////////////////////////////////////////////////

    // rates in quarters, refused requests are held and retried
    task automatic run_traffic(input int cycles, input int fetch_limit,
                               input int i_rate, input int d_rate);
        mem_req_t i_pend;
        mem_req_t d_pend;
        int       n;
        int       fetched;
        i_pend  = '0;
        d_pend  = '0;
        n       = 0;
        fetched = 0;
        while (n < cycles && fetched < fetch_limit) begin
            if (i_pend.command == BUS_NONE && rand_below(4) < i_rate) begin
                i_pend  = '{command: BUS_LOAD, addr: random_addr(), data: '0};
                fetched++;
            end
            if (d_pend.command == BUS_NONE && rand_below(4) < d_rate) begin
                d_pend = random_data_req();
            end
            bus_cycle(i_pend, d_pend);
            if (accept_owner == OWN_I) begin
                i_pend = '0;
            end
            if (accept_owner == OWN_D) begin
                d_pend = '0;
            end
            n++;
        end
        // drain, retry leftovers then wait out all replies
        while (i_pend.command != BUS_NONE || d_pend.command != BUS_NONE || book_live()) begin
            bus_cycle(i_pend, d_pend);
            if (accept_owner == OWN_I) begin
                i_pend = '0;
            end
            if (accept_owner == OWN_D) begin
                d_pend = '0;
            end
        end
        // last reply still to be compared
        bus_cycle('0, '0);
    endtask

    task automatic check_all_answered(input string name);
        if (delivered_count != accepted_count) begin
            $display("%s: %0d tags accepted but %0d replies delivered",
                name, accepted_count, delivered_count);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        if (errs == 0) begin
            $display("%s: ok", name);
            pass_count++;
        end else begin
            $display("%s: failed with %0d errors", name, errs);
            fail_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int errs;
        int stalls;
        clock        = 1'b0;
        reset        = 1'b1;
        icache_req   = '0;
        dcache_req   = '0;
        mem_response = '0;
        mem_reply    = '0;
        accept_owner = OWN_NONE;
        check_stall  = 1'b0;
        cycle_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        error_count  = 0;
        stall_errors = 0;
        book_clear();

        // reset held 5 cycles, then idle
        errs        = error_count;
        stalls      = stall_errors;
        check_stall = 1'b1;
        repeat (5) bus_cycle('0, '0);
        reset = 1'b0;
        repeat (3) bus_cycle('0, '0);
        check_stall = 1'b0;
        finish_test("test 1 reset", (error_count - errs) + (stall_errors - stalls));

        // both sides busy, then fetch alone
        errs = error_count;
        run_traffic(12, 12, 4, 4);
        run_traffic(6, 6, 4, 0);
        finish_test("test 2 priority", error_count - errs);

        errs            = error_count;
        accepted_count  = 0;
        delivered_count = 0;
        run_traffic(2000, 200, 4, 0);
        check_all_answered("test 3");
        finish_test("test 3 fetch loads", error_count - errs);

        // mixed traffic, stall watched every cycle
        errs            = error_count;
        stalls          = stall_errors;
        accepted_count  = 0;
        delivered_count = 0;
        check_stall     = 1'b1;
        run_traffic(1000, 1000, 2, 3);
        check_stall = 1'b0;
        check_all_answered("test 4");
        finish_test("test 4 mixed traffic", error_count - errs);
        finish_test("test 5 data stall", stall_errors - stalls);

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
src/mem_arb_pkg.sv
src/mem_request_select.sv
src/tag_owner_table.sv
src/reply_router.sv
src/mem_arbiter.sv
tests/mem_arbiter_tb.sv
